//--- design/router_macros.svh
`ifndef ROUTER_MACROS_SVH
`define ROUTER_MACROS_SVH

// Local, North, East, West and South.
`define NUM_PORTS 5

`define QUEUE_DEPTH 4 // flits held per input direction.

`define DATA_WIDTH 16

// packet length sits in the low bits of a header flit's data.
`define LEN_WIDTH 12

`endif

//--- design/routerPkg.sv
`default_nettype none

`include "router_macros.svh"

package routerPkg;

  typedef enum logic [2:0] {
    HEADER = 3'b001, // data low bits hold the packet length, header included.
    BODY   = 3'b010,
    TAIL   = 3'b100
  } flitTypeT;

  typedef enum logic [2:0] {
    LOCAL = 3'd0,
    NORTH = 3'd1,
    EAST  = 3'd2,
    WEST  = 3'd3,
    SOUTH = 3'd4
  } portIdxT;

  // bit 0 is idle and bit i+1 grants direction i.
  typedef logic [`NUM_PORTS:0] grantT;

  localparam grantT grantIdle = grantT'(1);

endpackage

`default_nettype wire

//--- design/flitQueue.sv
`timescale 1ns/1ns
`default_nettype none

`include "router_macros.svh"

module flitQueue
(
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         wrValid,
  input  wire routerPkg::flitTypeT    wrType,
  input  wire [`DATA_WIDTH-1:0]       wrData,
  input  wire                         pop,
  output logic                        wrReady,
  output logic                        headValid,
  output routerPkg::flitTypeT         headType,
  output logic [`DATA_WIDTH-1:0]      headData
);

  localparam int ptrWidth = $clog2(`QUEUE_DEPTH);
  localparam logic [ptrWidth:0] fullCount = (ptrWidth + 1)'(`QUEUE_DEPTH);
  localparam logic [ptrWidth-1:0] lastSlot = ptrWidth'(`QUEUE_DEPTH - 1);

  routerPkg::flitTypeT    typeMem [`QUEUE_DEPTH];
  logic [`DATA_WIDTH-1:0] dataMem [`QUEUE_DEPTH];
  logic [ptrWidth-1:0]    rdPtr;
  logic [ptrWidth-1:0]    wrPtr;
  logic [ptrWidth:0]      count;
  logic                   doWrite;
  logic                   doPop;

  assign wrReady   = (count != fullCount);
  assign headValid = (count != '0);
  assign doWrite   = wrValid && wrReady;
  assign doPop     = pop && headValid; // a pop on an empty queue is ignored.

  assign headType = typeMem[rdPtr]; // oldest flit is shown without a read delay.
  assign headData = dataMem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doWrite)
    begin
      typeMem[wrPtr] <= wrType;
      dataMem[wrPtr] <= wrData;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
      begin
        wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
      end
      if (doPop)
      begin
        rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
      end
      case ({doWrite, doPop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count; // both or neither leave the occupancy as it is.
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/holdTimer.sv
`timescale 1ns/1ns
`default_nettype none

`include "router_macros.svh"

module holdTimer
(
  input  wire                      clk,
  input  wire                      rst,
  input  wire routerPkg::flitTypeT headType,
  input  wire [`LEN_WIDTH-1:0]     headLength,
  input  wire                      granted,
  input  wire                      popped,
  output logic                     timesUp
);

  logic [`LEN_WIDTH-1:0] pktLength;
  logic [`LEN_WIDTH-1:0] fwdCount;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pktLength <= '0;
      fwdCount  <= '0;
    end
    else
    begin
      if (!granted && headType == routerPkg::HEADER)
      begin
        pktLength <= headLength; // captured while the direction waits its turn.
      end
      if (!granted)
      begin
        fwdCount <= '0;
      end
      else if (popped)
      begin
        fwdCount <= fwdCount + 1'b1; // stalled cycles do not count.
      end
    end
  end

  assign timesUp = (fwdCount == pktLength);

endmodule

`default_nettype wire

//--- design/packetArbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "router_macros.svh"

module packetArbiter
(
  input  wire                                        clk,
  input  wire                                        rst,
  input  wire [`NUM_PORTS-1:0]                       req,
  input  wire routerPkg::flitTypeT [`NUM_PORTS-1:0]  headType,
  input  wire [`NUM_PORTS-1:0][`LEN_WIDTH-1:0]       headLength,
  input  wire [`NUM_PORTS-1:0]                       pop,
  output routerPkg::grantT                           grant,
  output logic [`NUM_PORTS-1:0]                      timesUp
);

  logic [`NUM_PORTS-1:0] held;
  logic [`NUM_PORTS-1:0] keep;
  routerPkg::grantT      nextGrant;
  routerPkg::portIdxT    start;

  assign held = grant[`NUM_PORTS:1];

  // a holder stays on while its queue has flits and its packet is unfinished.
  assign keep = held & req & ~timesUp;

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : genTimer
    holdTimer hold
    (
      .clk(clk),
      .rst(rst),
      .headType(headType[i]),
      .headLength(headLength[i]),
      .granted(held[i]),
      .popped(pop[i]),
      .timesUp(timesUp[i])
    );
  end

  // The search starts one place after the holder, or at Local when idle.
  always_comb
  begin
    start = routerPkg::LOCAL;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (held[i])
      begin
        start = routerPkg::portIdxT'((i + 1) % `NUM_PORTS);
      end
    end
  end

  always_comb
  begin
    int idx;
    logic found;
    idx = 0;
    found = 1'b0;
    nextGrant = routerPkg::grantIdle; // nobody asking sends the state back to idle.
    if (|keep)
    begin
      nextGrant = grant;
    end
    else
    begin
      for (int k = 0; k < `NUM_PORTS; k++)
      begin
        idx = (int'(start) + k) % `NUM_PORTS;
        if (!found && req[idx] && !held[idx])
        begin
          nextGrant = '0;
          nextGrant[idx + 1] = 1'b1; // the old holder is never picked straight again.
          found = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= routerPkg::grantIdle;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

endmodule

`default_nettype wire

//--- design/switchStage.sv
`timescale 1ns/1ns
`default_nettype none

`include "router_macros.svh"

module switchStage
(
  input  wire                                        clk,
  input  wire                                        rst,
  input  wire routerPkg::grantT                      grant,
  input  wire [`NUM_PORTS-1:0]                       headValid,
  input  wire routerPkg::flitTypeT [`NUM_PORTS-1:0]  headType,
  input  wire [`NUM_PORTS-1:0][`DATA_WIDTH-1:0]      headData,
  input  wire [`NUM_PORTS-1:0]                       releasing,
  input  wire                                        outReady,
  output logic [`NUM_PORTS-1:0]                      pop,
  output logic                                       outValid,
  output routerPkg::flitTypeT                        outType,
  output logic [`DATA_WIDTH-1:0]                     outData,
  output routerPkg::portIdxT                         outSrc
);

  logic [`NUM_PORTS-1:0]  held;
  logic                   outFree;
  logic                   moving;
  routerPkg::portIdxT     selIdx;
  routerPkg::flitTypeT    selType;
  logic [`DATA_WIDTH-1:0] selData;

  assign held    = grant[`NUM_PORTS:1];
  assign outFree = !outValid || outReady; // empty now or emptied on this edge.

  always_comb
  begin
    selIdx = routerPkg::LOCAL;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (held[i])
      begin
        selIdx = routerPkg::portIdxT'(i);
      end
    end
  end

  assign selType = headType[selIdx];
  assign selData = headData[selIdx];

  // no pop once the timer marks the end of the packet.
  assign pop    = held & headValid & ~releasing & {`NUM_PORTS{outFree}};
  assign moving = |pop;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else if (moving)
    begin
      outValid <= 1'b1;
    end
    else if (outReady)
    begin
      outValid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (moving)
    begin
      outType <= selType;
      outData <= selData;
      outSrc  <= selIdx; // the next router returns credit to this direction.
    end
  end

endmodule

`default_nettype wire

//--- design/routerOutputPort.sv
`timescale 1ns/1ns
`default_nettype none

`include "router_macros.svh"

module routerOutputPort
(
  input  wire                                        clk,
  input  wire                                        rst,
  input  wire [`NUM_PORTS-1:0]                       inValid,
  input  wire routerPkg::flitTypeT [`NUM_PORTS-1:0]  inType,
  input  wire [`NUM_PORTS-1:0][`DATA_WIDTH-1:0]      inData,
  input  wire                                        outReady,
  output logic [`NUM_PORTS-1:0]                      inReady,
  output logic                                       outValid,
  output routerPkg::flitTypeT                        outType,
  output logic [`DATA_WIDTH-1:0]                     outData,
  output routerPkg::portIdxT                         outSrc
);

  logic [`NUM_PORTS-1:0]                      headValid;
  routerPkg::flitTypeT [`NUM_PORTS-1:0]       headType;
  logic [`NUM_PORTS-1:0][`DATA_WIDTH-1:0]     headData;
  logic [`NUM_PORTS-1:0][`LEN_WIDTH-1:0]      headLength;
  logic [`NUM_PORTS-1:0]                      pop;
  logic [`NUM_PORTS-1:0]                      timesUp;
  routerPkg::grantT                           grant;

  // Input buffering, one queue per direction.
  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : genQueue
    flitQueue queue
    (
      .clk(clk),
      .rst(rst),
      .wrValid(inValid[i]),
      .wrType(inType[i]),
      .wrData(inData[i]),
      .pop(pop[i]),
      .wrReady(inReady[i]),
      .headValid(headValid[i]),
      .headType(headType[i]),
      .headData(headData[i])
    );

    assign headLength[i] = headData[i][`LEN_WIDTH-1:0]; // only meaningful on a header.
  end

  packetArbiter arbiter
  (
    .clk(clk),
    .rst(rst),
    .req(headValid),
    .headType(headType),
    .headLength(headLength),
    .pop(pop),
    .grant(grant),
    .timesUp(timesUp)
  );

  switchStage switcher
  (
    .clk(clk),
    .rst(rst),
    .grant(grant),
    .headValid(headValid),
    .headType(headType),
    .headData(headData),
    .releasing(timesUp),
    .outReady(outReady),
    .pop(pop),
    .outValid(outValid),
    .outType(outType),
    .outData(outData),
    .outSrc(outSrc)
  );

endmodule

`default_nettype wire

//--- tests/tbScoreboard.svh
`ifndef TB_SCOREBOARD_SVH
`define TB_SCOREBOARD_SVH

localparam int flitW = `DATA_WIDTH + 3; // flit type sits above the data bits.

logic [flitW-1:0]   sendFlit [`NUM_PORTS][$]; // flits still to be offered per direction.
logic [flitW-1:0]   expFlit [`NUM_PORTS][$];  // flits still to be seen at the output.
routerPkg::portIdxT pktOrder [$];             // source of each packet in output order.
int                 flitsSent = 0;
int                 errCount = 0;
int                 pktLeft = 0;
routerPkg::portIdxT pktSrc = routerPkg::LOCAL;

// A header carries the packet length, and the last flit of a longer packet is a tail.
task automatic buildPacket(input routerPkg::portIdxT dir, input int len);
  logic [`DATA_WIDTH-1:0] word;
  routerPkg::flitTypeT    kind;
  for (int n = 0; n < len; n++)
  begin
    word = `DATA_WIDTH'($urandom);
    kind = routerPkg::BODY;
    if (n == 0)
    begin
      kind = routerPkg::HEADER;
      word[`LEN_WIDTH-1:0] = `LEN_WIDTH'(len);
    end
    else if (n == len - 1)
    begin
      kind = routerPkg::TAIL;
    end
    sendFlit[dir].push_back({kind, word});
    expFlit[dir].push_back({kind, word});
    flitsSent++;
  end
endtask

function automatic logic allDrained();
  logic drained;
  drained = 1'b1;
  for (int d = 0; d < `NUM_PORTS; d++)
  begin
    if (sendFlit[d].size() != 0 || expFlit[d].size() != 0)
    begin
      drained = 1'b0;
    end
  end
  return drained;
endfunction

task automatic checkOutFlit(input logic [flitW-1:0] got, input routerPkg::portIdxT src);
  logic [flitW-1:0] want;
  want = '0;
  if (pktLeft != 0 && src != pktSrc)
  begin
    $display("packet from direction %0d was interleaved with direction %0d", pktSrc, src);
    errCount++;
  end
  if (src >= `NUM_PORTS)
  begin
    $display("output flit names direction %0d, which does not exist", src);
    errCount++;
  end
  else if (expFlit[src].size() == 0)
  begin
    $display("unexpected extra flit from direction %0d", src);
    errCount++;
  end
  else
  begin
    want = expFlit[src].pop_front();
    if (got[flitW-1:`DATA_WIDTH] != want[flitW-1:`DATA_WIDTH])
    begin
      $display("** Error outType (src %0d): expected 0x%h got 0x%h", src,
               want[flitW-1:`DATA_WIDTH], got[flitW-1:`DATA_WIDTH]);
      errCount++;
    end
    if (got[`DATA_WIDTH-1:0] != want[`DATA_WIDTH-1:0])
    begin
      $display("** Error outData (src %0d): expected 0x%h got 0x%h", src,
               want[`DATA_WIDTH-1:0], got[`DATA_WIDTH-1:0]);
      errCount++;
    end
  end
  if (pktLeft == 0)
  begin
    pktLeft = int'(want[`LEN_WIDTH-1:0]); // the expected header gives the packet length.
    pktSrc = src;
    pktOrder.push_back(src);
  end
  if (pktLeft != 0)
  begin
    pktLeft--;
  end
endtask

`endif

//--- tests/tbRouterOutputPort.sv
`timescale 1ns/1ns
`default_nettype none

`include "router_macros.svh"

module tbRouterOutputPort;

  logic                                   clk;
  logic                                   rst;
  logic [`NUM_PORTS-1:0]                  inValid;
  routerPkg::flitTypeT [`NUM_PORTS-1:0]   inType;
  logic [`NUM_PORTS-1:0][`DATA_WIDTH-1:0] inData;
  logic                                   outReady;
  logic [`NUM_PORTS-1:0]                  inReady;
  logic                                   outValid;
  routerPkg::flitTypeT                    outType;
  logic [`DATA_WIDTH-1:0]                 outData;
  routerPkg::portIdxT                     outSrc;
  logic                                   sawFull;
  int                                     passCount;
  int                                     failCount;

  `include "tbScoreboard.svh"

  routerOutputPort dut0
  (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inType(inType),
    .inData(inData),
    .outReady(outReady),
    .inReady(inReady),
    .outValid(outValid),
    .outType(outType),
    .outData(outData),
    .outSrc(outSrc)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Each direction offers the front of its list until its queue takes it.
  initial
  begin : offerFlits
    logic [`NUM_PORTS-1:0] readyNow;
    logic [flitW-1:0]      flit;
    inValid = '0;
    inData  = '0;
    sawFull = 1'b0;
    for (int d = 0; d < `NUM_PORTS; d++)
    begin
      inType[d] = routerPkg::HEADER;
    end
    forever
    begin
      @(negedge clk);
      readyNow = inReady; // stable until the next rising edge.
      @(posedge clk);
      #1;
      for (int d = 0; d < `NUM_PORTS; d++)
      begin
        if (inValid[d] && readyNow[d])
        begin
          void'(sendFlit[d].pop_front());
        end
        if (inValid[d] && !readyNow[d])
        begin
          sawFull = 1'b1;
        end
        inValid[d] = (sendFlit[d].size() != 0);
        if (inValid[d])
        begin
          flit = sendFlit[d][0];
          inType[d] = routerPkg::flitTypeT'(flit[flitW-1:`DATA_WIDTH]);
          inData[d] = flit[`DATA_WIDTH-1:0];
        end
      end
    end
  end

  initial
  begin : watchOutput
    logic               stalled;
    logic [flitW-1:0]   heldFlit;
    routerPkg::portIdxT heldSrc;
    stalled = 1'b0;
    heldFlit = '0;
    heldSrc = routerPkg::LOCAL;
    forever
    begin
      @(negedge clk);
      if (stalled && (!outValid || {outType, outData} != heldFlit || outSrc != heldSrc))
      begin
        $display("output flit changed while outReady was low at %0t", $time);
        errCount++;
      end
      if (outValid && outReady && !rst)
      begin
        checkOutFlit({outType, outData}, outSrc);
      end
      stalled = outValid && !outReady && !rst;
      heldFlit = {outType, outData};
      heldSrc = outSrc;
    end
  end

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= flitsSent * 4 + 200)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles with %0d flits sent", cycles, flitsSent);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic stepCycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic waitDrain();
    while (!allDrained())
    begin
      stepCycles(1);
    end
    stepCycles(6); // room for a stray extra flit to show up.
  endtask

  task automatic finishTest(input string name, input int errBefore);
    if (errCount == errBefore)
    begin
      passCount++;
      $display("%s: ok", name);
    end
    else
    begin
      failCount++;
      $display("%s: %0d errors", name, errCount - errBefore);
    end
  endtask

  task automatic resetAndSingle();
    int errBefore;
    errBefore = errCount;
    @(negedge clk);
    if (outValid !== 1'b0)
    begin
      $display("** Error outValid: expected 0x0 got 0x%h", outValid);
      errCount++;
    end
    if (inReady !== {`NUM_PORTS{1'b1}})
    begin
      $display("** Error inReady: expected 0x%h got 0x%h", {`NUM_PORTS{1'b1}}, inReady);
      errCount++;
    end
    buildPacket(routerPkg::LOCAL, 1);
    waitDrain();
    finishTest("test 1 reset and single flit", errBefore);
  endtask

  task automatic packetHold();
    int errBefore;
    errBefore = errCount;
    pktOrder.delete();
    buildPacket(routerPkg::NORTH, 5);
    buildPacket(routerPkg::EAST, 3);
    waitDrain();
    if (pktOrder.size() != 2 || pktOrder[0] != routerPkg::NORTH || pktOrder[1] != routerPkg::EAST)
    begin
      $display("North and East packets did not leave in idle priority order");
      errCount++;
    end
    finishTest("test 2 packet hold", errBefore);
  endtask

  task automatic rotationFairness();
    int                 errBefore;
    routerPkg::portIdxT want;
    errBefore = errCount;
    pktOrder.delete();
    for (int r = 0; r < 3; r++)
    begin
      for (int d = 0; d < `NUM_PORTS; d++)
      begin
        buildPacket(routerPkg::portIdxT'(d), 2 + int'($urandom % 3));
      end
    end
    waitDrain();
    if (pktOrder.size() != 3 * `NUM_PORTS)
    begin
      $display("rotation test saw %0d packets instead of 15", pktOrder.size());
      errCount++;
    end
    for (int i = 0; i < pktOrder.size(); i++)
    begin
      want = routerPkg::portIdxT'(i % `NUM_PORTS); // every queue is busy, so strict rotation.
      if (pktOrder[i] != want)
      begin
        $display("** Error outSrc: packet %0d expected 0x%h got 0x%h", i, want, pktOrder[i]);
        errCount++;
      end
    end
    finishTest("test 3 rotation fairness", errBefore);
  endtask

  task automatic backPressure();
    int errBefore;
    int stall;
    errBefore = errCount;
    sawFull = 1'b0;
    buildPacket(routerPkg::WEST, 8);
    buildPacket(routerPkg::SOUTH, 6);
    buildPacket(routerPkg::LOCAL, 5);
    buildPacket(routerPkg::EAST, 7);
    for (int s = 0; s < 6; s++)
    begin
      stall = (s == 0) ? 10 : 2 + int'($urandom % 7);
      outReady = 1'b0;
      stepCycles(stall);
      outReady = 1'b1;
      stepCycles(2 + int'($urandom % 4));
    end
    waitDrain();
    if (!sawFull)
    begin
      $display("no input queue filled up while the output was stalled");
      errCount++;
    end
    finishTest("test 4 back-pressure", errBefore);
  endtask

  task automatic randomMix();
    int errBefore;
    errBefore = errCount;
    for (int p = 0; p < 30; p++)
    begin
      buildPacket(routerPkg::portIdxT'($urandom % `NUM_PORTS), 1 + int'($urandom % 8));
      stepCycles(1 + int'($urandom % 3));
    end
    waitDrain();
    finishTest("test 5 random mix", errBefore);
  endtask

  initial
  begin
    passCount = 0;
    failCount = 0;
    rst = 1'b1;
    outReady = 1'b1;
    void'($urandom(25894));
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    resetAndSingle();
    packetHold();
    rotationFairness();
    backPressure();
    randomMix();
    $display("tests ok %0d, tests failed %0d, errors %0d", passCount, failCount, errCount);
    if (failCount == 0 && errCount == 0)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+design
+incdir+tests
design/routerPkg.sv
design/flitQueue.sv
design/holdTimer.sv
design/packetArbiter.sv
design/switchStage.sv
design/routerOutputPort.sv
tests/tbRouterOutputPort.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log.
verilator --binary --timing -j 0 --top-module tbRouterOutputPort -f filelist.f -o simRouter \
  && ./obj_dir/simRouter > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; exit 1; }
grep -qx "=== PASS ===" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
